//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := rename_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "run failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- filelist.f
+incdir+rtl
rtl/rename_pkg.sv
rtl/rat.sv
rtl/rob.sv
rtl/rename_top.sv
verification/rename_tb.sv

//--- rtl/rat.sv
`include "rename_cfg.svh"

// register alias table
// maps each areg to the rob entry that will produce it
module rat (
    input  logic                      clk,
    input  logic                      resetn,
    input  rename_pkg::rename_instr_t instr_accepted [`MACHINE_WIDTH],
    input  rename_pkg::retire_t       retire         [`RETIRE_PORTS],
    input  rename_pkg::rob_id_t       rob_addr_new   [`MACHINE_WIDTH],
    output rename_pkg::rename_info_t  renaming_info  [`MACHINE_WIDTH]
);
    import rename_pkg::*;

    // committed table
    table_t map_q;
    // table after this cycle's retires
    table_t map_cleared;
    // table after retires and group writes
    table_t map_next;

    // per slot mapping write enable
    logic [`MACHINE_WIDTH-1:0] wr_en;

    // a slot writes only when accepted and dst is not r0
    always_comb begin
        for (int i = 0; i < `MACHINE_WIDTH; i++) begin
            wr_en[i] = instr_accepted[i].valid && (instr_accepted[i].dst != '0);
        end
    end

    // retire clearing
    // only drop the mapping if it still points at the retired entry,
    // a newer rename of the same register must survive
    always_comb begin
        map_cleared = map_q;
        for (int j = 0; j < `RETIRE_PORTS; j++) begin
            if (retire[j].valid &&
                map_cleared[retire[j].dst].valid &&
                map_cleared[retire[j].dst].id == retire[j].rob_id) begin
                map_cleared[retire[j].dst] = '0;
            end
        end
    end

    // source and previous dst lookup
    // base value from the cleared table
    // then writes of older slots in the group, in program order
    always_comb begin
        for (int i = 0; i < `MACHINE_WIDTH; i++) begin
            renaming_info[i].src1 = map_cleared[instr_accepted[i].src1];
            renaming_info[i].src2 = map_cleared[instr_accepted[i].src2];
            renaming_info[i].dst  = map_cleared[instr_accepted[i].dst];
            // later j overrides earlier j, so the youngest older writer wins
            for (int j = 0; j < i; j++) begin
                if (wr_en[j] && instr_accepted[j].dst == instr_accepted[i].src1) begin
                    renaming_info[i].src1 = {1'b1, rob_addr_new[j]};
                end
                if (wr_en[j] && instr_accepted[j].dst == instr_accepted[i].src2) begin
                    renaming_info[i].src2 = {1'b1, rob_addr_new[j]};
                end
                if (wr_en[j] && instr_accepted[j].dst == instr_accepted[i].dst) begin
                    renaming_info[i].dst = {1'b1, rob_addr_new[j]};
                end
            end
        end
    end

    // group writes on top of the retire clear
    // rename beats retire on the same register
    // higher slot applied last, so it wins on a duplicate dst
    always_comb begin
        map_next = map_cleared;
        for (int i = 0; i < `MACHINE_WIDTH; i++) begin
            if (wr_en[i]) begin
                map_next[instr_accepted[i].dst] = {1'b1, rob_addr_new[i]};
            end
        end
    end

    // table register, all entries invalid out of reset
    always_ff @(posedge clk) begin
        if (!resetn) begin
            map_q <= '0;
        end else begin
            map_q <= map_next;
        end
    end

endmodule

//--- rtl/rename_cfg.svh
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// instructions renamed per cycle
`define MACHINE_WIDTH 2

// rob entries retired per cycle
`define RETIRE_PORTS 2

// architectural register file
`define ARCH_REGS 32
// index width, log2 of ARCH_REGS
`define AREG_W 5

// reorder buffer size
`define ROB_DEPTH 16
// rob id width, log2 of ROB_DEPTH
// depth must stay a power of two so pointers wrap for free
`define ROB_W 4

`endif

//--- rtl/rename_pkg.sv
`include "rename_cfg.svh"

package rename_pkg;

    // architectural register index, r0 never renamed
    typedef logic [`AREG_W-1:0] areg_t;

    // rob entry id, doubles as the rename tag
    typedef logic [`ROB_W-1:0] rob_id_t;

    // one alias table slot
    // valid means the register waits on rob entry id
    typedef struct packed {
        logic    valid;
        rob_id_t id;
    } map_entry_t;

    // whole alias table, indexed by areg
    typedef map_entry_t [`ARCH_REGS-1:0] table_t;

    // one instruction entering rename
    typedef struct packed {
        logic  valid;
        areg_t dst;
        areg_t src1;
        areg_t src2;
    } rename_instr_t;

    // rename result per slot
    // dst carries the previous mapping of the dst register
    typedef struct packed {
        map_entry_t src1;
        map_entry_t src2;
        map_entry_t dst;
    } rename_info_t;

    // one retiring rob entry
    typedef struct packed {
        logic    valid;
        areg_t   dst;
        rob_id_t rob_id;
    } retire_t;

    // writeback strobe, marks an entry done
    typedef struct packed {
        logic    valid;
        rob_id_t rob_id;
    } wb_t;

    // rob occupancy
    // empty and full both have head == tail, the state tells them apart
    typedef enum logic [1:0] {
        ROB_EMPTY,
        ROB_ACTIVE,
        ROB_FULL
    } rob_state_t;

endpackage

//--- rtl/rename_top.sv
`include "rename_cfg.svh"

// rename front end
// rob hands out tags and retires, rat tracks the mapping
module rename_top (
    input  logic                      clk,
    input  logic                      resetn,
    input  rename_pkg::rename_instr_t instr         [`MACHINE_WIDTH],
    input  rename_pkg::wb_t           wb            [`MACHINE_WIDTH],
    output rename_pkg::rename_info_t  renaming_info [`MACHINE_WIDTH],
    output rename_pkg::rob_id_t       rob_addr_new  [`MACHINE_WIDTH],
    output rename_pkg::retire_t       retire        [`RETIRE_PORTS],
    output logic                      stall
);
    import rename_pkg::*;

    // group after stall gating, only rob looks at stall
    rename_instr_t instr_accepted [`MACHINE_WIDTH];

    // tag allocation, completion and retire
    rob rob_i (
        .clk            (clk),
        .resetn         (resetn),
        .instr          (instr),
        .wb             (wb),
        .instr_accepted (instr_accepted),
        .rob_addr_new   (rob_addr_new),
        .retire         (retire),
        .stall          (stall)
    );

    // mapping lookup and update
    // new tags come straight from rob, same cycle
    // retire feeds back to clear stale mappings
    rat rat_i (
        .clk            (clk),
        .resetn         (resetn),
        .instr_accepted (instr_accepted),
        .retire         (retire),
        .rob_addr_new   (rob_addr_new),
        .renaming_info  (renaming_info)
    );

endmodule

//--- rtl/rob.sv
`include "rename_cfg.svh"

// reorder buffer
// in order allocate, out of order complete, in order retire
module rob (
    input  logic                      clk,
    input  logic                      resetn,
    input  rename_pkg::rename_instr_t instr          [`MACHINE_WIDTH],
    input  rename_pkg::wb_t           wb             [`MACHINE_WIDTH],
    output rename_pkg::rename_instr_t instr_accepted [`MACHINE_WIDTH],
    output rename_pkg::rob_id_t       rob_addr_new   [`MACHINE_WIDTH],
    output rename_pkg::retire_t       retire         [`RETIRE_PORTS],
    output logic                      stall
);
    import rename_pkg::*;

    // per entry payload, no reset needed
    areg_t dst_mem [`ROB_DEPTH];
    // per entry completion flag
    logic [`ROB_DEPTH-1:0] done_q;

    // oldest entry and next free entry
    rob_id_t head_q;
    rob_id_t tail_q;

    rob_state_t state_q;
    rob_state_t state_next;

    // occupancy counts, one bit wider than an id to hold ROB_DEPTH
    logic [`ROB_W:0] used;
    logic [`ROB_W:0] used_next;
    logic [`ROB_W:0] free_cnt;
    logic [`ROB_W:0] n_alloc;
    logic [`ROB_W:0] n_retire;

    // retire candidates for the next edge
    retire_t retire_next [`RETIRE_PORTS];

    // entries in use
    // head == tail is either empty or full, state decides
    always_comb begin
        rob_id_t span;
        span = tail_q - head_q;
        if (state_q == ROB_FULL) begin
            used = (`ROB_W+1)'(`ROB_DEPTH);
        end else begin
            used = {1'b0, span};
        end
    end

    assign free_cnt = (`ROB_W+1)'(`ROB_DEPTH) - used;

    // stall whole group if a full group might not fit
    assign stall = free_cnt < (`ROB_W+1)'(`MACHINE_WIDTH);

    // allocation
    // valid slots take consecutive ids from tail, in slot order
    always_comb begin
        logic [`ROB_W:0] cnt;
        cnt = '0;
        for (int i = 0; i < `MACHINE_WIDTH; i++) begin
            instr_accepted[i]       = instr[i];
            instr_accepted[i].valid = instr[i].valid && !stall;
            rob_addr_new[i]         = tail_q + cnt[`ROB_W-1:0];
            if (instr_accepted[i].valid) begin
                cnt = cnt + 1'b1;
            end
        end
        n_alloc = cnt;
    end

    // retire selection
    // consecutive done entries from head, stop at first not done
    always_comb begin
        logic            run;
        rob_id_t         idx;
        logic [`ROB_W:0] cnt;
        run = 1'b1;
        cnt = '0;
        for (int k = 0; k < `RETIRE_PORTS; k++) begin
            idx = head_q + rob_id_t'(k);
            // entry must be occupied as well as done
            run = run && ((`ROB_W+1)'(k) < used) && done_q[idx];
            retire_next[k].valid  = run;
            retire_next[k].dst    = dst_mem[idx];
            retire_next[k].rob_id = idx;
            if (run) begin
                cnt = cnt + 1'b1;
            end
        end
        n_retire = cnt;
    end

    // occupancy fsm
    always_comb begin
        used_next = used + n_alloc - n_retire;
        if (used_next == '0) begin
            state_next = ROB_EMPTY;
        end else if (used_next == (`ROB_W+1)'(`ROB_DEPTH)) begin
            state_next = ROB_FULL;
        end else begin
            state_next = ROB_ACTIVE;
        end
    end

    // pointers, state, done flags and registered retire
    always_ff @(posedge clk) begin
        if (!resetn) begin
            head_q  <= '0;
            tail_q  <= '0;
            state_q <= ROB_EMPTY;
            done_q  <= '0;
            for (int k = 0; k < `RETIRE_PORTS; k++) begin
                retire[k] <= '0;
            end
        end else begin
            head_q  <= head_q + n_retire[`ROB_W-1:0];
            tail_q  <= tail_q + n_alloc[`ROB_W-1:0];
            state_q <= state_next;
            retire  <= retire_next;
            // retiring entries free their done bit
            for (int k = 0; k < `RETIRE_PORTS; k++) begin
                if (retire_next[k].valid) begin
                    done_q[retire_next[k].rob_id] <= 1'b0;
                end
            end
            // fresh entries start not done
            for (int i = 0; i < `MACHINE_WIDTH; i++) begin
                if (instr_accepted[i].valid) begin
                    done_q[rob_addr_new[i]] <= 1'b0;
                end
            end
            // writeback last, sets done
            for (int i = 0; i < `MACHINE_WIDTH; i++) begin
                if (wb[i].valid) begin
                    done_q[wb[i].rob_id] <= 1'b1;
                end
            end
        end
    end

    // dst payload, written on allocate
    always_ff @(posedge clk) begin
        for (int i = 0; i < `MACHINE_WIDTH; i++) begin
            if (instr_accepted[i].valid) begin
                dst_mem[rob_addr_new[i]] <= instr[i].dst;
            end
        end
    end

endmodule

//--- verification/rename_patterns.txt
# name | i0 v dst s1 s2 | i1 v dst s1 s2 | wb0 v id | wb1 v id | exp i0 s1 s2 pdst | i1 s1 s2 pdst
# | addr0 addr1 | ret0 v dst id | ret1 v dst id | stall   (map entries hex {valid,id})
reset_clear     0 00 05 06 0 00 07 08 0 0 0 0 00 00 00 00 00 00 0 0 0 00 0 0 00 0 0
reset_clear     0 00 1f 1e 0 00 03 04 0 0 0 0 00 00 00 00 00 00 0 0 0 00 0 0 00 0 0
basic_rename    1 01 00 00 1 02 00 00 0 0 0 0 00 00 00 00 00 00 0 1 0 00 0 0 00 0 0
basic_rename    1 03 01 02 0 00 00 00 0 0 0 0 10 11 00 00 00 00 2 3 0 00 0 0 00 0 0
group_bypass    1 04 05 03 1 05 04 04 0 0 0 0 00 12 00 13 13 00 3 4 0 00 0 0 00 0 0
group_bypass    1 06 00 00 1 06 06 00 0 0 0 0 00 00 00 15 00 15 5 6 0 00 0 0 00 0 0
group_bypass    1 00 06 00 1 07 00 00 0 0 0 0 16 00 00 00 00 00 7 8 0 00 0 0 00 0 0
group_bypass    0 00 00 06 0 00 07 00 0 0 0 0 00 16 00 18 00 00 9 9 0 00 0 0 00 0 0
in_order_retire 0 00 00 00 0 00 00 00 1 1 1 2 00 00 00 00 00 00 9 9 0 00 0 0 00 0 0
in_order_retire 0 00 00 00 0 00 00 00 1 0 0 0 00 00 00 00 00 00 9 9 0 00 0 0 00 0 0
in_order_retire 0 00 00 00 0 00 00 00 0 0 0 0 00 00 00 00 00 00 9 9 0 00 0 0 00 0 0
in_order_retire 0 00 00 00 0 00 00 00 0 0 0 0 00 00 00 00 00 00 9 9 1 01 0 1 02 1 0
in_order_retire 0 00 00 00 0 00 00 00 1 3 1 4 00 00 00 00 00 00 9 9 1 03 2 0 00 0 0
in_order_retire 0 00 00 00 0 00 00 00 0 0 0 0 00 00 00 00 00 00 9 9 0 00 0 0 00 0 0
in_order_retire 0 00 00 00 0 00 00 00 0 0 0 0 00 00 00 00 00 00 9 9 1 04 3 1 05 4 0
retire_match    0 00 01 04 0 00 06 07 1 5 1 7 00 00 00 16 18 00 9 9 0 00 0 0 00 0 0
retire_match    0 00 00 00 0 00 00 00 0 0 0 0 00 00 00 00 00 00 9 9 0 00 0 0 00 0 0
retire_match    0 00 06 00 0 00 00 00 0 0 0 0 16 00 00 00 00 00 9 9 1 06 5 0 00 0 0
retire_match    0 00 06 00 0 00 00 00 1 6 1 8 16 00 00 00 00 00 9 9 0 00 0 0 00 0 0
retire_match    0 00 06 00 0 00 00 00 0 0 0 0 16 00 00 00 00 00 9 9 0 00 0 0 00 0 0
retire_match    0 00 06 00 0 00 00 00 0 0 0 0 00 00 00 00 00 00 9 9 1 06 6 1 00 7 0
retire_match    0 00 07 06 0 00 00 00 0 0 0 0 00 00 00 00 00 00 9 9 1 07 8 0 00 0 0
full_stall      1 08 00 00 1 09 00 00 0 0 0 0 00 00 00 00 00 00 9 a 0 00 0 0 00 0 0
full_stall      1 08 00 00 1 09 00 00 0 0 0 0 00 00 19 00 00 1a b c 0 00 0 0 00 0 0
full_stall      1 08 00 00 1 09 00 00 0 0 0 0 00 00 1b 00 00 1c d e 0 00 0 0 00 0 0
full_stall      1 08 00 00 1 09 00 00 0 0 0 0 00 00 1d 00 00 1e f 0 0 00 0 0 00 0 0
full_stall      1 08 00 00 1 09 00 00 0 0 0 0 00 00 1f 00 00 10 1 2 0 00 0 0 00 0 0
full_stall      1 08 00 00 1 09 00 00 0 0 0 0 00 00 11 00 00 12 3 4 0 00 0 0 00 0 0
full_stall      1 08 00 00 1 09 00 00 0 0 0 0 00 00 13 00 00 14 5 6 0 00 0 0 00 0 0
full_stall      1 08 00 00 0 00 00 00 0 0 0 0 00 00 15 00 00 00 7 8 0 00 0 0 00 0 0
full_stall      1 08 08 09 1 09 08 00 1 9 1 a 17 16 17 17 00 16 8 8 0 00 0 0 00 0 1
full_stall      1 08 08 09 1 09 08 00 0 0 0 0 17 16 17 17 00 16 8 8 0 00 0 0 00 0 1
full_stall      1 08 08 09 1 09 08 00 0 0 0 0 17 16 17 18 00 16 8 9 1 08 9 1 09 a 0
full_stall      0 00 08 09 0 00 00 00 0 0 0 0 18 19 00 00 00 00 a a 0 00 0 0 00 0 1

//--- verification/rename_tb.sv
`include "rename_cfg.svh"

// testbench for the rename front end
// one pattern line per clock cycle from the patterns file
module rename_tb;
    import rename_pkg::*;

    // number of hex columns after the test name
    localparam int NUM_COLS = 27;
    localparam int RESET_CYCLES = 8;

    logic clk;
    logic resetn;

    rename_instr_t instr         [`MACHINE_WIDTH];
    wb_t           wb            [`MACHINE_WIDTH];
    rename_info_t  renaming_info [`MACHINE_WIDTH];
    rob_id_t       rob_addr_new  [`MACHINE_WIDTH];
    retire_t       retire        [`RETIRE_PORTS];
    logic          stall;

    // pattern lines with comments stripped
    string lines [$];
    // columns of the current line
    logic [7:0] col [NUM_COLS];

    string cur_name;
    string line_name;
    int    test_errs;
    int    total_errs;
    int    checks;
    int    tests_run;
    int    tests_failed;
    int    cycle_cnt;
    int    cycle_limit;

    rename_top rename_top_i (
        .clk           (clk),
        .resetn        (resetn),
        .instr         (instr),
        .wb            (wb),
        .renaming_info (renaming_info),
        .rob_addr_new  (rob_addr_new),
        .retire        (retire),
        .stall         (stall)
    );

    // 4 unit clock
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // run limit set once the patterns are loaded
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles, patterns did not finish", cycle_cnt);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // single compare for values up to 8 bits
    task automatic check_field(input string what, input logic [7:0] exp,
                               input logic [7:0] got);
        checks = checks + 1;
        assert (got === exp) else begin
            $display("[FAIL] %s %s expected %h actual %h", cur_name, what, exp, got);
            test_errs = test_errs + 1;
        end
    endtask

    // per test summary line
    task automatic report_test();
        tests_run = tests_run + 1;
        if (test_errs != 0) begin
            tests_failed = tests_failed + 1;
            $display("test %s: failed with %0d errors", cur_name, test_errs);
        end else begin
            $display("test %s: ok", cur_name);
        end
        total_errs = total_errs + test_errs;
        test_errs  = 0;
    endtask

    // drive the input columns
    // cols 0..7 instr and 8..11 wb
    task automatic apply_line();
        for (int i = 0; i < `MACHINE_WIDTH; i++) begin
            instr[i].valid = col[4*i][0];
            instr[i].dst   = col[4*i+1][`AREG_W-1:0];
            instr[i].src1  = col[4*i+2][`AREG_W-1:0];
            instr[i].src2  = col[4*i+3][`AREG_W-1:0];
            wb[i].valid    = col[8+2*i][0];
            wb[i].rob_id   = col[8+2*i+1][`ROB_W-1:0];
        end
    endtask

    // compare outputs against cols 12..26
    task automatic check_line();
        for (int i = 0; i < `MACHINE_WIDTH; i++) begin
            check_field($sformatf("slot%0d src1", i), col[12+3*i],
                        8'(renaming_info[i].src1));
            check_field($sformatf("slot%0d src2", i), col[13+3*i],
                        8'(renaming_info[i].src2));
            check_field($sformatf("slot%0d prev dst", i), col[14+3*i],
                        8'(renaming_info[i].dst));
            check_field($sformatf("slot%0d rob_addr_new", i), col[18+i],
                        8'(rob_addr_new[i]));
        end
        for (int k = 0; k < `RETIRE_PORTS; k++) begin
            check_field($sformatf("retire%0d valid", k), col[20+3*k], 8'(retire[k].valid));
            // payload only meaningful when valid
            if (col[20+3*k][0]) begin
                check_field($sformatf("retire%0d dst", k), col[21+3*k],
                            8'(retire[k].dst));
                check_field($sformatf("retire%0d rob_id", k), col[22+3*k],
                            8'(retire[k].rob_id));
            end
        end
        check_field("stall", col[26], 8'(stall));
    endtask

    initial begin
        int    fd;
        int    n;
        string raw;

        // inputs idle
        resetn = 1'b0;
        for (int i = 0; i < `MACHINE_WIDTH; i++) begin
            instr[i] = '0;
            wb[i]    = '0;
        end
        cur_name     = "";
        test_errs    = 0;
        total_errs   = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cycle_cnt    = 0;
        cycle_limit  = 0;

        fd = $fopen("verification/rename_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file");
            total_errs = total_errs + 1;
        end else begin
            while (!$feof(fd)) begin
                raw = "";
                n = $fgets(raw, fd);
                // skip blanks and # comment lines
                if (n > 1 && raw.getc(0) != 8'h23) begin
                    lines.push_back(raw);
                end
            end
            $fclose(fd);
        end

        cycle_limit = lines.size() + RESET_CYCLES + 20;

        // hold reset then release just after an edge
        repeat (RESET_CYCLES) @(posedge clk);
        #1 resetn = 1'b1;

        foreach (lines[l]) begin
            n = $sscanf(lines[l],
                "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                line_name, col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                col[7], col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                col[15], col[16], col[17], col[18], col[19], col[20], col[21], col[22],
                col[23], col[24], col[25], col[26]);
            if (n != NUM_COLS + 1) begin
                $display("pattern line %0d is malformed, read %0d fields", l, n);
                total_errs = total_errs + 1;
            end else begin
                // name change closes the previous test
                if (line_name != cur_name) begin
                    if (cur_name != "") begin
                        report_test();
                    end
                    cur_name = line_name;
                end
                apply_line();
                // sample well before the next edge
                #2;
                check_line();
            end
            @(posedge clk);
            #1;
        end
        if (cur_name != "") begin
            report_test();
        end

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, total_errs);
        if (total_errs == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
